//--- list.f
source/csr_pkg.sv
source/csr_regfile.sv
source/csr_timer.sv
source/csr_trap_ctrl.sv
source/csr_top.sv
tb/csr_properties.sv
tb/csr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the csr testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module csr_tb -f list.f -Mdir obj_dir -o csr_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/csr_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- source/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // standard machine csrs
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hb02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hb82;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hf14;

    // timer block mapped into custom csr space
    localparam logic [CSR_ADDR_W-1:0] CSR_MSIP      = 12'hbc0;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIME     = 12'hbc1;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIMEH    = 12'hbc2;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIMECMP  = 12'hbc3;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTIMECMPH = 12'hbc4;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCCTR     = 12'hbc5;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // same positions in mip
    localparam int MIE_MSIE_BIT = 3;
    localparam int MIE_MTIE_BIT = 7;
    localparam int MIE_MEIE_BIT = 11;

    localparam int MCCTR_INSTRET_EN_BIT = 1;
    localparam int MCCTR_TIMER_EN_BIT   = 2;

    localparam logic [XLEN-1:0] CAUSE_MSI = 32'h8000_0003;
    localparam logic [XLEN-1:0] CAUSE_MTI = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_MEI = 32'h8000_000b;

    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100; // mxl=1, I

endpackage

//--- source/csr_regfile.sv
module csr_regfile #(
    parameter logic [csr_pkg::XLEN-1:0] HART_ID     = '0,
    parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ex_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] ex_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       ex_wdata_i,
    output logic [csr_pkg::XLEN-1:0]       ex_rdata_o,
    input  logic                           trap_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] trap_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       trap_wdata_i,
    output logic [csr_pkg::XLEN-1:0]       trap_rdata_o,
    input  logic                           retire_i,
    input  logic [63:0]                    mtime_i,
    input  logic [63:0]                    mtimecmp_i,
    input  logic                           timer_pending_i,
    input  logic                           ext_irq_i,
    output logic                           mstatus_mie_o,
    output logic [csr_pkg::XLEN-1:0]       mepc_o,
    output logic [2:0]                     mie_bits_o,
    output logic                           msip_o,
    output logic                           timer_en_o,
    output logic                           time_wr_lo_o,
    output logic                           time_wr_hi_o,
    output logic                           cmp_wr_lo_o,
    output logic                           cmp_wr_hi_o
);

    logic                           mstatus_mpie;
    logic                           mie_meie, mie_mtie, mie_msie;
    logic [csr_pkg::XLEN-1:0]       mtvec, mscratch, mcause, mtval;
    logic                           instret_en;
    logic [63:0]                    minstret;
    logic [csr_pkg::XLEN-1:0]       mstatus_val, mie_val, mip_val, mcctr_val;

    // merged write port, execute stage first
    logic                           wr_en;
    logic [csr_pkg::CSR_ADDR_W-1:0] wr_addr;
    logic [csr_pkg::XLEN-1:0]       wr_data;

    assign wr_en   = ex_we_i | trap_we_i;
    assign wr_addr = ex_we_i ? ex_addr_i : trap_addr_i;
    assign wr_data = ex_we_i ? ex_wdata_i : trap_wdata_i;

    assign time_wr_lo_o = ex_we_i && (ex_addr_i == csr_pkg::CSR_MTIME);
    assign time_wr_hi_o = ex_we_i && (ex_addr_i == csr_pkg::CSR_MTIMEH);
    assign cmp_wr_lo_o  = ex_we_i && (ex_addr_i == csr_pkg::CSR_MTIMECMP);
    assign cmp_wr_hi_o  = ex_we_i && (ex_addr_i == csr_pkg::CSR_MTIMECMPH);

    assign mie_bits_o = {mie_meie, mie_mtie, mie_msie};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie_o <= 1'b0;
            mstatus_mpie  <= 1'b0;
            mtvec         <= MTVEC_RESET;
            mie_meie      <= 1'b0;
            mie_mtie      <= 1'b0;
            mie_msie      <= 1'b0;
            msip_o        <= 1'b0;
            instret_en    <= 1'b0;
            timer_en_o    <= 1'b0;
        end else begin
            if (wr_en && wr_addr == csr_pkg::CSR_MSTATUS) begin
                mstatus_mie_o <= wr_data[csr_pkg::MSTATUS_MIE_BIT];
                mstatus_mpie  <= wr_data[csr_pkg::MSTATUS_MPIE_BIT];
            end
            if (wr_en && wr_addr == csr_pkg::CSR_MTVEC)
                mtvec <= wr_data;
            if (ex_we_i) begin
                case (ex_addr_i)
                    csr_pkg::CSR_MIE: begin
                        mie_meie <= ex_wdata_i[csr_pkg::MIE_MEIE_BIT];
                        mie_mtie <= ex_wdata_i[csr_pkg::MIE_MTIE_BIT];
                        mie_msie <= ex_wdata_i[csr_pkg::MIE_MSIE_BIT];
                    end
                    csr_pkg::CSR_MSIP: msip_o <= ex_wdata_i[0];
                    csr_pkg::CSR_MCCTR: begin
                        instret_en <= ex_wdata_i[csr_pkg::MCCTR_INSTRET_EN_BIT];
                        timer_en_o <= ex_wdata_i[csr_pkg::MCCTR_TIMER_EN_BIT];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_we_i && ex_addr_i == csr_pkg::CSR_MSCRATCH)
            mscratch <= ex_wdata_i;
        if (wr_en && wr_addr == csr_pkg::CSR_MEPC)
            mepc_o <= wr_data;
        if (wr_en && wr_addr == csr_pkg::CSR_MCAUSE)
            mcause <= wr_data;
        if (wr_en && wr_addr == csr_pkg::CSR_MTVAL)
            mtval <= wr_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            minstret <= '0;
        else if (ex_we_i && ex_addr_i == csr_pkg::CSR_MINSTRET)
            minstret[31:0] <= ex_wdata_i;
        else if (ex_we_i && ex_addr_i == csr_pkg::CSR_MINSTRETH)
            minstret[63:32] <= ex_wdata_i;
        else if (retire_i && instret_en)
            minstret <= minstret + 64'd1;
    end

    always_comb begin
        mstatus_val = '0;
        mstatus_val[12:11] = 2'b11; // mpp fixed to machine
        mstatus_val[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie_o;
        mstatus_val[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;
        mie_val = '0;
        mie_val[csr_pkg::MIE_MEIE_BIT] = mie_meie;
        mie_val[csr_pkg::MIE_MTIE_BIT] = mie_mtie;
        mie_val[csr_pkg::MIE_MSIE_BIT] = mie_msie;
        mip_val = '0; // live lines, not latched
        mip_val[csr_pkg::MIE_MEIE_BIT] = ext_irq_i;
        mip_val[csr_pkg::MIE_MTIE_BIT] = timer_pending_i;
        mip_val[csr_pkg::MIE_MSIE_BIT] = msip_o;
        mcctr_val = '0;
        mcctr_val[csr_pkg::MCCTR_INSTRET_EN_BIT] = instret_en;
        mcctr_val[csr_pkg::MCCTR_TIMER_EN_BIT]   = timer_en_o;
    end

    always_comb begin
        case (ex_addr_i)
            csr_pkg::CSR_MSTATUS:   ex_rdata_o = mstatus_val;
            csr_pkg::CSR_MISA:      ex_rdata_o = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MIE:       ex_rdata_o = mie_val;
            csr_pkg::CSR_MTVEC:     ex_rdata_o = mtvec;
            csr_pkg::CSR_MSCRATCH:  ex_rdata_o = mscratch;
            csr_pkg::CSR_MEPC:      ex_rdata_o = mepc_o;
            csr_pkg::CSR_MCAUSE:    ex_rdata_o = mcause;
            csr_pkg::CSR_MTVAL:     ex_rdata_o = mtval;
            csr_pkg::CSR_MIP:       ex_rdata_o = mip_val;
            csr_pkg::CSR_MINSTRET:  ex_rdata_o = minstret[31:0];
            csr_pkg::CSR_MINSTRETH: ex_rdata_o = minstret[63:32];
            csr_pkg::CSR_MHARTID:   ex_rdata_o = HART_ID;
            csr_pkg::CSR_MSIP:      ex_rdata_o = {{(csr_pkg::XLEN-1){1'b0}}, msip_o};
            csr_pkg::CSR_MTIME:     ex_rdata_o = mtime_i[31:0];
            csr_pkg::CSR_MTIMEH:    ex_rdata_o = mtime_i[63:32];
            csr_pkg::CSR_MTIMECMP:  ex_rdata_o = mtimecmp_i[31:0];
            csr_pkg::CSR_MTIMECMPH: ex_rdata_o = mtimecmp_i[63:32];
            csr_pkg::CSR_MCCTR:     ex_rdata_o = mcctr_val;
            default:                ex_rdata_o = '0;
        endcase
    end

    // trap side only sees the trap registers
    always_comb begin
        case (trap_addr_i)
            csr_pkg::CSR_MSTATUS: trap_rdata_o = mstatus_val;
            csr_pkg::CSR_MTVEC:   trap_rdata_o = mtvec;
            csr_pkg::CSR_MEPC:    trap_rdata_o = mepc_o;
            csr_pkg::CSR_MCAUSE:  trap_rdata_o = mcause;
            csr_pkg::CSR_MTVAL:   trap_rdata_o = mtval;
            default:              trap_rdata_o = '0;
        endcase
    end

endmodule

//--- source/csr_timer.sv
module csr_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     timer_en_i,
    input  logic                     time_wr_lo_i,
    input  logic                     time_wr_hi_i,
    input  logic                     cmp_wr_lo_i,
    input  logic                     cmp_wr_hi_i,
    input  logic [csr_pkg::XLEN-1:0] wdata_i,
    output logic [63:0]              mtime_o,
    output logic [63:0]              mtimecmp_o,
    output logic                     timer_pending_o
);

    // a half write holds the count for that cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mtime_o <= '0;
        else if (time_wr_lo_i)
            mtime_o[31:0] <= wdata_i;
        else if (time_wr_hi_i)
            mtime_o[63:32] <= wdata_i;
        else if (timer_en_i)
            mtime_o <= mtime_o + 64'd1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mtimecmp_o <= '1; // max, nothing pending out of reset
        else if (cmp_wr_lo_i)
            mtimecmp_o[31:0] <= wdata_i;
        else if (cmp_wr_hi_i)
            mtimecmp_o[63:32] <= wdata_i;
    end

    assign timer_pending_o = (mtime_o >= mtimecmp_o);

endmodule

//--- source/csr_top.sv
module csr_top #(
    parameter logic [csr_pkg::XLEN-1:0] HART_ID     = '0,
    parameter logic [csr_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           ex_we_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] ex_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       ex_wdata_i,
    output logic [csr_pkg::XLEN-1:0]       ex_rdata_o,
    input  logic                           ext_irq_i,
    input  logic                           retire_i,
    input  logic [csr_pkg::XLEN-1:0]       retire_pc_i,
    input  logic                           mret_i,
    output logic                           redirect_o,
    output logic [csr_pkg::XLEN-1:0]       redirect_pc_o,
    output logic                           trap_busy_o
);

    logic                           trap_we;
    logic [csr_pkg::CSR_ADDR_W-1:0] trap_addr;
    logic [csr_pkg::XLEN-1:0]       trap_wdata, trap_rdata;
    logic                           mstatus_mie, msip, timer_en, timer_pending;
    logic [2:0]                     mie_bits;
    logic [csr_pkg::XLEN-1:0]       mepc;
    logic                           time_wr_lo, time_wr_hi, cmp_wr_lo, cmp_wr_hi;
    logic [63:0]                    mtime, mtimecmp;

    csr_regfile #(
        .HART_ID     (HART_ID),
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regfile (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_we_i         (ex_we_i),
        .ex_addr_i       (ex_addr_i),
        .ex_wdata_i      (ex_wdata_i),
        .ex_rdata_o      (ex_rdata_o),
        .trap_we_i       (trap_we),
        .trap_addr_i     (trap_addr),
        .trap_wdata_i    (trap_wdata),
        .trap_rdata_o    (trap_rdata),
        .retire_i        (retire_i),
        .mtime_i         (mtime),
        .mtimecmp_i      (mtimecmp),
        .timer_pending_i (timer_pending),
        .ext_irq_i       (ext_irq_i),
        .mstatus_mie_o   (mstatus_mie),
        .mepc_o          (mepc),
        .mie_bits_o      (mie_bits),
        .msip_o          (msip),
        .timer_en_o      (timer_en),
        .time_wr_lo_o    (time_wr_lo),
        .time_wr_hi_o    (time_wr_hi),
        .cmp_wr_lo_o     (cmp_wr_lo),
        .cmp_wr_hi_o     (cmp_wr_hi)
    );

    csr_timer u_timer (
        .clk             (clk),
        .rst_n           (rst_n),
        .timer_en_i      (timer_en),
        .time_wr_lo_i    (time_wr_lo),
        .time_wr_hi_i    (time_wr_hi),
        .cmp_wr_lo_i     (cmp_wr_lo),
        .cmp_wr_hi_i     (cmp_wr_hi),
        .wdata_i         (ex_wdata_i),  // timer writes only come from execute
        .mtime_o         (mtime),
        .mtimecmp_o      (mtimecmp),
        .timer_pending_o (timer_pending)
    );

    csr_trap_ctrl u_trap (
        .clk             (clk),
        .rst_n           (rst_n),
        .retire_i        (retire_i),
        .retire_pc_i     (retire_pc_i),
        .mret_i          (mret_i),
        .ext_irq_i       (ext_irq_i),
        .msip_i          (msip),
        .timer_pending_i (timer_pending),
        .mie_bits_i      (mie_bits),
        .mstatus_mie_i   (mstatus_mie),
        .mepc_i          (mepc),
        .trap_rdata_i    (trap_rdata),
        .trap_we_o       (trap_we),
        .trap_addr_o     (trap_addr),
        .trap_wdata_o    (trap_wdata),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o),
        .trap_busy_o     (trap_busy_o)
    );

endmodule

//--- source/csr_trap_ctrl.sv
module csr_trap_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           retire_i,
    input  logic [csr_pkg::XLEN-1:0]       retire_pc_i,
    input  logic                           mret_i,
    input  logic                           ext_irq_i,
    input  logic                           msip_i,
    input  logic                           timer_pending_i,
    input  logic [2:0]                     mie_bits_i,
    input  logic                           mstatus_mie_i,
    input  logic [csr_pkg::XLEN-1:0]       mepc_i,
    input  logic [csr_pkg::XLEN-1:0]       trap_rdata_i,
    output logic                           trap_we_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0] trap_addr_o,
    output logic [csr_pkg::XLEN-1:0]       trap_wdata_o,
    output logic                           redirect_o,
    output logic [csr_pkg::XLEN-1:0]       redirect_pc_o,
    output logic                           trap_busy_o
);

    localparam logic [csr_pkg::XLEN-1:0] INSN_BYTES = 4;

    typedef enum logic [2:0] {
        TRAP_IDLE,
        TRAP_SAVE_EPC,
        TRAP_SAVE_CAUSE,
        TRAP_SAVE_STATUS,
        RET_STATUS,
        TRAP_JUMP
    } trap_state_e;

    trap_state_e              state_q, state_d;
    logic [2:0]               pend;     // {mei, mti, msi} after mie
    logic                     take;
    logic                     ret_q;    // jump target is mepc
    logic [csr_pkg::XLEN-1:0] epc_q, cause_q, cause_d;

    assign pend = {ext_irq_i, timer_pending_i, msip_i} & mie_bits_i;
    assign take = retire_i && mstatus_mie_i && (|pend);

    // mei > msi > mti
    assign cause_d = pend[2] ? csr_pkg::CAUSE_MEI :
                     pend[0] ? csr_pkg::CAUSE_MSI : csr_pkg::CAUSE_MTI;

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRAP_IDLE: begin
                if (mret_i)
                    state_d = RET_STATUS;
                else if (take)
                    state_d = TRAP_SAVE_EPC;
            end
            TRAP_SAVE_EPC:    state_d = TRAP_SAVE_CAUSE;
            TRAP_SAVE_CAUSE:  state_d = TRAP_SAVE_STATUS;
            TRAP_SAVE_STATUS: state_d = TRAP_JUMP;
            RET_STATUS:       state_d = TRAP_JUMP;
            default:          state_d = TRAP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TRAP_IDLE;
            ret_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == TRAP_IDLE && (mret_i || take))
                ret_q <= mret_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == TRAP_IDLE && take) begin
            epc_q   <= retire_pc_i + INSN_BYTES;
            cause_q <= cause_d;
        end
    end

    always_comb begin
        trap_we_o    = 1'b0;
        trap_addr_o  = csr_pkg::CSR_MTVEC;
        trap_wdata_o = trap_rdata_i;
        case (state_q)
            TRAP_SAVE_EPC: begin
                trap_we_o    = 1'b1;
                trap_addr_o  = csr_pkg::CSR_MEPC;
                trap_wdata_o = epc_q;
            end
            TRAP_SAVE_CAUSE: begin
                trap_we_o    = 1'b1;
                trap_addr_o  = csr_pkg::CSR_MCAUSE;
                trap_wdata_o = cause_q;
            end
            TRAP_SAVE_STATUS: begin // read-modify-write of mstatus
                trap_we_o    = 1'b1;
                trap_addr_o  = csr_pkg::CSR_MSTATUS;
                trap_wdata_o[csr_pkg::MSTATUS_MPIE_BIT] = trap_rdata_i[csr_pkg::MSTATUS_MIE_BIT];
                trap_wdata_o[csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
            end
            RET_STATUS: begin
                trap_we_o    = 1'b1;
                trap_addr_o  = csr_pkg::CSR_MSTATUS;
                trap_wdata_o[csr_pkg::MSTATUS_MIE_BIT]  = trap_rdata_i[csr_pkg::MSTATUS_MPIE_BIT];
                trap_wdata_o[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
            end
            default: ;
        endcase
    end

    assign redirect_o    = (state_q == TRAP_JUMP);
    assign redirect_pc_o = ret_q ? mepc_i : {trap_rdata_i[csr_pkg::XLEN-1:2], 2'b00};
    assign trap_busy_o   = (state_q != TRAP_IDLE);

endmodule

//--- tb/csr_properties.sv
module csr_properties (
    input logic       clk,
    input logic       rst_n,
    input logic       retire_i,
    input logic       mret_i,
    input logic       ext_irq_i,
    input logic       msip_i,
    input logic       timer_pending_i,
    input logic [2:0] mie_bits_i,
    input logic       mstatus_mie_i,
    input logic       redirect_i,
    input logic       trap_busy_i
);

    int   assert_fails = 0;
    logic take_trap;
    logic take_ret;

    // {mei, mti, msi} lines against mie
    assign take_trap = retire_i && !mret_i && !trap_busy_i && mstatus_mie_i
                       && |({ext_irq_i, timer_pending_i, msip_i} & mie_bits_i);
    assign take_ret  = mret_i && !trap_busy_i;

    a_trap_frame: assert property (@(posedge clk) disable iff (!rst_n)
        take_trap |=> (trap_busy_i && !redirect_i) ##1 (trap_busy_i && !redirect_i)
                      ##1 (trap_busy_i && !redirect_i) ##1 (trap_busy_i && redirect_i))
        else begin
            assert_fails++;
            $error("trap entry did not redirect 4 cycles after retire with busy held");
        end

    a_ret_frame: assert property (@(posedge clk) disable iff (!rst_n)
        take_ret |=> (trap_busy_i && !redirect_i) ##1 (trap_busy_i && redirect_i))
        else begin
            assert_fails++;
            $error("mret did not redirect 2 cycles after the strobe with busy held");
        end

    a_busy_drops: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i |-> trap_busy_i ##1 !trap_busy_i)
        else begin
            assert_fails++;
            $error("busy not framing the redirect cycle");
        end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !redirect_i && !trap_busy_i)
        else begin
            assert_fails++;
            $error("redirect or busy high during reset");
        end

endmodule

bind csr_top csr_properties u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .retire_i        (retire_i),
    .mret_i          (mret_i),
    .ext_irq_i       (ext_irq_i),
    .msip_i          (msip),
    .timer_pending_i (timer_pending),
    .mie_bits_i      (mie_bits),
    .mstatus_mie_i   (mstatus_mie),
    .redirect_i      (redirect_o),
    .trap_busy_i     (trap_busy_o)
);

//--- tb/csr_tb.sv
module csr_tb;

    localparam logic [31:0] HART      = 32'd5;
    localparam logic [31:0] MTVEC0    = 32'h100;
    localparam int          WAIT_MAX  = 32;
    localparam int          NUM_TESTS = 6;

    localparam logic [31:0] MIE_ALL = (32'd1 << csr_pkg::MIE_MEIE_BIT)
                                    | (32'd1 << csr_pkg::MIE_MTIE_BIT)
                                    | (32'd1 << csr_pkg::MIE_MSIE_BIT);
    localparam logic [31:0] MSTATUS_MIE_ON = 32'd1 << csr_pkg::MSTATUS_MIE_BIT;

    logic        clk;
    logic        rst_n;
    logic        ex_we;
    logic [11:0] ex_addr;
    logic [31:0] ex_wdata;
    logic [31:0] ex_rdata;
    logic        ext_irq;
    logic        retire;
    logic [31:0] retire_pc;
    logic        mret;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        trap_busy;

    logic [31:0] lfsr;
    int          errors;
    int          test_start_errors;
    int          tests_failed;

    csr_top #(
        .HART_ID     (HART),
        .MTVEC_RESET (MTVEC0)
    ) u_csr_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_we_i       (ex_we),
        .ex_addr_i     (ex_addr),
        .ex_wdata_i    (ex_wdata),
        .ex_rdata_o    (ex_rdata),
        .ext_irq_i     (ext_irq),
        .retire_i      (retire),
        .retire_pc_i   (retire_pc),
        .mret_i        (mret),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .trap_busy_o   (trap_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int total_errors();
        return errors + u_csr_top.u_props.assert_fails;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        ex_we    <= 1'b1;
        ex_addr  <= addr;
        ex_wdata <= data;
        @(posedge clk);
        ex_we    <= 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        ex_addr <= addr;
        @(negedge clk); // combinational read, settled by now
        data = ex_rdata;
    endtask

    task automatic readback(input logic [11:0] addr, input string name);
        logic [31:0] v;
        logic [31:0] w;
        draw_bits(32, v);
        csr_write(addr, v);
        csr_read(addr, w);
        check_eq(name, w, v);
    endtask

    task automatic retire_pulse(input logic [31:0] pc);
        @(posedge clk);
        retire    <= 1'b1;
        retire_pc <= pc;
        @(posedge clk);
        retire    <= 1'b0;
    endtask

    task automatic mret_pulse();
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
    endtask

    task automatic wait_redirect(output logic [31:0] pc);
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        pc   = '0;
        while (!seen && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
            if (redirect) begin
                seen = 1'b1;
                pc   = redirect_pc;
            end
        end
        if (!seen) begin
            $display("timeout: no redirect within %0d cycles at time %0t", WAIT_MAX, $time);
            errors++;
        end
    endtask

    task automatic retire_expect_none(input int count);
        logic [31:0] pc;
        for (int i = 0; i < count; i++) begin
            draw_bits(30, pc);
            retire_pulse({pc[29:0], 2'b00});
            repeat (6) begin
                @(negedge clk);
                check_eq("redirect while masked", {31'b0, redirect}, 32'd0);
            end
        end
    endtask

    task automatic start_test();
        test_start_errors = total_errors();
    endtask

    task automatic end_test(input string name);
        if (total_errors() == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, total_errors() - test_start_errors);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] pc;
        int          n;
        lfsr         = 32'hfc97;
        errors       = 0;
        tests_failed = 0;
        rst_n     <= 1'b0;
        ex_we     <= 1'b0;
        ex_addr   <= '0;
        ex_wdata  <= '0;
        ext_irq   <= 1'b0;
        retire    <= 1'b0;
        retire_pc <= '0;
        mret      <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        readback(csr_pkg::CSR_MSCRATCH, "mscratch");
        readback(csr_pkg::CSR_MEPC, "mepc");
        readback(csr_pkg::CSR_MTVAL, "mtval");
        csr_read(csr_pkg::CSR_MHARTID, w);
        check_eq("mhartid", w, 32'd5);
        csr_read(csr_pkg::CSR_MISA, w);
        check_eq("misa", w, csr_pkg::MISA_VALUE);
        csr_read(12'h7c0, w); // nothing mapped here
        check_eq("unmapped csr", w, 32'd0);
        end_test("register read-back");

        start_test();
        csr_write(csr_pkg::CSR_MCCTR, 32'd1 << csr_pkg::MCCTR_TIMER_EN_BIT);
        csr_read(csr_pkg::CSR_MTIME, t0);
        csr_read(csr_pkg::CSR_MTIME, t1);
        check_eq("mtime step", t1 - t0, 32'd1);
        csr_write(csr_pkg::CSR_MTIMECMPH, 32'd0);
        csr_write(csr_pkg::CSR_MTIMECMP, 32'd0);
        csr_read(csr_pkg::CSR_MIP, v);
        check_eq("mip.mtip", {31'b0, v[csr_pkg::MIE_MTIE_BIT]}, 32'd1);
        end_test("timer counting");

        start_test();
        csr_write(csr_pkg::CSR_MSIP, 32'd1); // msi and mti both pending now
        csr_write(csr_pkg::CSR_MIE, 32'd0);
        csr_write(csr_pkg::CSR_MSTATUS, MSTATUS_MIE_ON);
        retire_expect_none(3);
        csr_write(csr_pkg::CSR_MIE, MIE_ALL);
        csr_write(csr_pkg::CSR_MSTATUS, 32'd0);
        retire_expect_none(3);
        csr_write(csr_pkg::CSR_MSIP, 32'd0);
        csr_write(csr_pkg::CSR_MTIMECMPH, '1);
        csr_write(csr_pkg::CSR_MTIMECMP, '1);
        end_test("masking");

        start_test();
        csr_write(csr_pkg::CSR_MSTATUS, MSTATUS_MIE_ON);
        @(posedge clk);
        ext_irq <= 1'b1;
        draw_bits(30, pc);
        pc = {pc[29:0], 2'b00};
        retire_pulse(pc);
        wait_redirect(v);
        check_eq("mei trap target", v, MTVEC0 & ~32'd3);
        @(posedge clk);
        ext_irq <= 1'b0;
        csr_read(csr_pkg::CSR_MEPC, w);
        check_eq("mepc after mei", w, pc + 32'd4);
        csr_read(csr_pkg::CSR_MCAUSE, w);
        check_eq("mcause after mei", w, csr_pkg::CAUSE_MEI);
        csr_read(csr_pkg::CSR_MSTATUS, w);
        check_eq("mstatus.mie in trap", {31'b0, w[csr_pkg::MSTATUS_MIE_BIT]}, 32'd0);
        check_eq("mstatus.mpie in trap", {31'b0, w[csr_pkg::MSTATUS_MPIE_BIT]}, 32'd1);
        csr_write(csr_pkg::CSR_MSIP, 32'd1);
        csr_write(csr_pkg::CSR_MSTATUS, MSTATUS_MIE_ON);
        draw_bits(30, pc);
        pc = {pc[29:0], 2'b00};
        retire_pulse(pc);
        wait_redirect(v);
        check_eq("msi trap target", v, MTVEC0 & ~32'd3);
        csr_read(csr_pkg::CSR_MCAUSE, w);
        check_eq("mcause after msi", w, csr_pkg::CAUSE_MSI);
        csr_write(csr_pkg::CSR_MSIP, 32'd0);
        end_test("trap entry");

        start_test();
        mret_pulse();
        wait_redirect(v);
        check_eq("mret target", v, pc + 32'd4);
        csr_read(csr_pkg::CSR_MSTATUS, w);
        check_eq("mstatus.mie after mret", {31'b0, w[csr_pkg::MSTATUS_MIE_BIT]}, 32'd1);
        end_test("return");

        start_test();
        csr_write(csr_pkg::CSR_MCCTR, (32'd1 << csr_pkg::MCCTR_INSTRET_EN_BIT)
                                    | (32'd1 << csr_pkg::MCCTR_TIMER_EN_BIT));
        csr_read(csr_pkg::CSR_MINSTRET, t0);
        draw_bits(3, v);
        n = 4 + int'(v[2:0]);
        repeat (n) retire_pulse(32'h0);
        csr_read(csr_pkg::CSR_MINSTRET, t1);
        check_eq("minstret delta", t1 - t0, 32'(n));
        end_test("retire counter");

        repeat (4) @(posedge clk); // let the last properties settle
        $display("tests %0d, failed %0d, errors %0d (assertions %0d)", NUM_TESTS,
                 tests_failed, total_errors(), u_csr_top.u_props.assert_fails);
        if (total_errors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
